//--- hw/tx_pkg.sv
/*
 * Shared types and constants of the 802.11a transmit bit front end.
 * Modules take them with a wildcard import in the module header.
 * Covers field and rate codes, the bit and coded pair structs
 * and the widths of the packet memory and of the PLCP fields.
 */
`default_nettype none

package tx_pkg;

    ////////////////////
    // Memory and field widths
    ////////////////////
    localparam int MEM_WORD_W   = 64;
    localparam int MEM_ADDR_W   = 10;
    localparam int SIGNAL_BITS  = 24;
    localparam int SERVICE_BITS = 16;
    localparam int TAIL_BITS    = 6;
    localparam int FCS_BITS     = 32;
    localparam int SCRAM_W      = 7;

    // Field in progress, also the sequencer state
    typedef enum logic [2:0] {
        IDLE, SIGNAL, SERVICE, PSDU, FCS, TAIL, PAD, DONE
    } field_e;

    // SIGNAL rate codes, bits 3 to 0 of word 0
    typedef enum logic [3:0] {
        RATE_6  = 4'b1011,
        RATE_9  = 4'b1111,
        RATE_12 = 4'b1010,
        RATE_18 = 4'b1110,
        RATE_24 = 4'b1001,
        RATE_36 = 4'b1101,
        RATE_48 = 4'b1000,
        RATE_54 = 4'b1100
    } rate_e;

    // One uncoded bit with its field tag
    typedef struct packed {
        logic   data;
        field_e field;
        logic   first;
    } tx_bit_t;

    // Encoder outputs, a from 133 octal and b from 171 octal
    typedef struct packed {
        logic a;
        logic b;
    } coded_pair_t;

endpackage

`default_nettype wire

//--- hw/crc32_fcs.sv
/*
 * Bit-serial CRC-32 for the frame check sequence.
 * Preset on the first SIGNAL bit, fed by PSDU bits, then shifted out
 * inverted during the FCS field, most significant bit first.
 */
`timescale 1ns/10ps
`default_nettype none

module crc32_fcs
    import tx_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    reset_int,
    input  wire tx_bit_t i_bit,
    input  wire logic    i_crc_strobe,
    output logic         o_fcs_bit
);

    localparam logic [31:0] CRC_POLY = 32'h04C1_1DB7;

    logic [31:0] crc;
    logic        feedback;

    assign feedback  = i_bit.data ^ crc[31];
    assign o_fcs_bit = ~crc[31];

    always_ff @(posedge clk) begin
        if (reset_int) begin
            crc <= '1;
        end else if (i_crc_strobe) begin
            case (i_bit.field)
                SIGNAL: begin
                    if (i_bit.first) begin
                        crc <= '1;
                    end
                end
                PSDU:    crc <= {crc[30:0], 1'b0} ^ (feedback ? CRC_POLY : 32'h0);
                // Present the next FCS bit
                FCS:     crc <= {crc[30:0], 1'b0};
                default: crc <= crc;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/data_scrambler.sv
/*
 * Data scrambler with generator x^7 + x^4 + 1.
 * Seeded at the first SERVICE bit of each packet, it leaves SIGNAL bits
 * alone and zeroes the TAIL bits while its state holds.
 */
`timescale 1ns/10ps
`default_nettype none

module data_scrambler
    import tx_pkg::*;
(
    input  wire logic               clk,
    input  wire logic               reset_int,
    input  wire logic [SCRAM_W-1:0] i_scram_seed,
    input  wire tx_bit_t            i_bit,
    input  wire logic               i_bit_strobe,
    output tx_bit_t                 o_bit
);

    logic [SCRAM_W-1:0] scram_state;
    logic [SCRAM_W-1:0] cur_state;
    logic               scram_fb;
    logic               advance;

    // The seed takes effect on the very first SERVICE bit
    assign cur_state = (i_bit.field == SERVICE && i_bit.first) ? i_scram_seed : scram_state;
    assign scram_fb  = cur_state[6] ^ cur_state[3];

    always_comb begin
        o_bit   = i_bit;
        advance = 1'b0;
        case (i_bit.field)
            SERVICE, PSDU, FCS, PAD: begin
                o_bit.data = i_bit.data ^ scram_fb;
                advance    = 1'b1;
            end
            TAIL:    o_bit.data = 1'b0;
            default: o_bit.data = i_bit.data;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_int) begin
            scram_state <= '0;
        end else if (i_bit_strobe && advance) begin
            scram_state <= {cur_state[SCRAM_W-2:0], scram_fb};
        end
    end

endmodule

`default_nettype wire

//--- hw/conv_encoder.sv
/*
 * Rate-1/2 convolutional encoder, constraint length 7.
 * Output a uses generator 133 octal and b uses 171 octal.
 * The history is cleared ahead of SIGNAL and ahead of SERVICE.
 */
`timescale 1ns/10ps
`default_nettype none

module conv_encoder
    import tx_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    reset_int,
    input  wire tx_bit_t i_bit,
    input  wire logic    i_bit_strobe,
    output coded_pair_t  o_pair,
    output logic         o_pair_strobe
);

    localparam logic [6:0] GEN_A = 7'o133;
    localparam logic [6:0] GEN_B = 7'o171;

    logic [5:0] history;      // Bit 5 is the most recent input
    logic [5:0] cur_hist;
    logic [6:0] window;
    logic       clear_hist;

    assign clear_hist = i_bit.first && (i_bit.field == SIGNAL || i_bit.field == SERVICE);
    assign cur_hist   = clear_hist ? 6'd0 : history;

    // Window MSB is the new bit, LSB the oldest delay tap
    assign window = {i_bit.data, cur_hist};

    assign o_pair.a      = ^(window & GEN_A);
    assign o_pair.b      = ^(window & GEN_B);
    assign o_pair_strobe = i_bit_strobe;

    always_ff @(posedge clk) begin
        if (reset_int) begin
            history <= '0;
        end else if (i_bit_strobe) begin
            history <= {i_bit.data, cur_hist[5:1]};
        end
    end

endmodule

`default_nettype wire

//--- hw/coded_pair_fifo.sv
/*
 * Circular buffer of coded bit pairs between the encoder and the output.
 * Full stalls the sequencer upstream, and the read side is a plain
 * ready/valid stream. Depth must be a power of two, 4 or more.
 */
`timescale 1ns/10ps
`default_nettype none

module coded_pair_fifo
    import tx_pkg::*;
#(
    parameter int FIFO_DEPTH = 16
) (
    input  wire logic        clk,
    input  wire logic        reset_int,
    input  wire coded_pair_t i_pair,
    input  wire logic        i_pair_strobe,
    input  wire logic        i_pair_ready,
    output coded_pair_t      o_pair,
    output logic             o_pair_valid,
    output logic             o_full,
    output logic             o_empty
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    coded_pair_t mem [FIFO_DEPTH];

    // Pointers carry one wrap bit above the index
    logic [PTR_W:0] wr_ptr;
    logic [PTR_W:0] rd_ptr;
    logic           wr_en;
    logic           rd_en;

    assign o_empty = (wr_ptr == rd_ptr);
    assign o_full  = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
                     (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);

    assign wr_en = i_pair_strobe && !o_full;
    assign rd_en = o_pair_valid && i_pair_ready;

    assign o_pair_valid = !o_empty;
    assign o_pair       = mem[rd_ptr[PTR_W-1:0]];

    ////////////////////
    // Storage
    ////////////////////
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr[PTR_W-1:0]] <= i_pair;
        end
    end

    ////////////////////
    // Pointers
    ////////////////////
    always_ff @(posedge clk) begin
        if (reset_int) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/frame_sequencer.sv
/*
 * Field sequencer of the transmitter.
 * Walks SIGNAL, SERVICE, PSDU, FCS, TAIL and PAD, one bit per cycle
 * while the coded pair FIFO has room, and addresses the packet memory.
 * Ack is raised once the FIFO has drained after the last bit.
 */
`timescale 1ns/10ps
`default_nettype none

module frame_sequencer
    import tx_pkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  reset_int,
    input  wire logic                  i_tx_req,
    input  wire logic [MEM_WORD_W-1:0] i_mem_data,
    input  wire logic                  i_fcs_bit,
    input  wire logic                  i_fifo_full,
    input  wire logic                  i_fifo_empty,
    output logic                       o_tx_ack,
    output logic      [MEM_ADDR_W-1:0] o_mem_addr,
    output tx_bit_t                    o_bit,
    output logic                       o_bit_strobe,
    output logic                       o_crc_strobe
);

    field_e      state;
    field_e      next_field;
    logic [14:0] fld_cnt;       // Bit index inside the current field
    logic [14:0] psdu_bits;     // Up to 8 * 4091 payload bits
    logic [7:0]  sym_cnt;       // Data bits into the current OFDM symbol
    logic [7:0]  dbps;
    logic [7:0]  dbps_dec;
    logic [11:0] sig_len;
    logic        emit;
    logic        field_last;
    logic        sym_wrap;

    assign emit         = (state != IDLE) && (state != DONE) && !i_fifo_full;
    assign o_bit_strobe = emit;
    assign o_crc_strobe = emit && (state == SIGNAL || state == PSDU || state == FCS);
    assign sym_wrap     = (sym_cnt == dbps - 8'd1);
    assign sig_len      = i_mem_data[16:5];

    ////////////////////
    // Rate decode
    ////////////////////
    always_comb begin
        case (rate_e'(i_mem_data[3:0]))
            RATE_6:  dbps_dec = 8'd24;
            RATE_9:  dbps_dec = 8'd36;
            RATE_12: dbps_dec = 8'd48;
            RATE_18: dbps_dec = 8'd72;
            RATE_24: dbps_dec = 8'd96;
            RATE_36: dbps_dec = 8'd144;
            RATE_48: dbps_dec = 8'd192;
            RATE_54: dbps_dec = 8'd216;
            default: dbps_dec = 8'd24;
        endcase
    end

    ////////////////////
    // Field end detection
    ////////////////////
    always_comb begin
        field_last = 1'b0;
        next_field = state;
        case (state)
            SIGNAL: begin
                field_last = (fld_cnt == 15'(SIGNAL_BITS - 1));
                next_field = SERVICE;
            end
            SERVICE: begin
                field_last = (fld_cnt == 15'(SERVICE_BITS - 1));
                // Empty payload goes straight to the FCS
                next_field = (psdu_bits == '0) ? FCS : PSDU;
            end
            PSDU: begin
                field_last = (fld_cnt == psdu_bits - 15'd1);
                next_field = FCS;
            end
            FCS: begin
                field_last = (fld_cnt == 15'(FCS_BITS - 1));
                next_field = TAIL;
            end
            TAIL: begin
                field_last = (fld_cnt == 15'(TAIL_BITS - 1));
                next_field = sym_wrap ? DONE : PAD;
            end
            PAD: begin
                field_last = sym_wrap;
                next_field = DONE;
            end
            default: begin
                field_last = 1'b0;
                next_field = state;
            end
        endcase
    end

    // Bit selection, LSB first within each memory word
    always_comb begin
        o_bit.field = state;
        o_bit.first = (fld_cnt == '0);
        case (state)
            SIGNAL:  o_bit.data = i_mem_data[fld_cnt[4:0]];
            PSDU:    o_bit.data = i_mem_data[fld_cnt[5:0]];
            FCS:     o_bit.data = i_fcs_bit;
            default: o_bit.data = 1'b0;
        endcase
    end

    ////////////////////
    // Field FSM
    ////////////////////
    always_ff @(posedge clk) begin
        if (reset_int) begin
            state      <= IDLE;
            fld_cnt    <= '0;
            sym_cnt    <= '0;
            dbps       <= 8'd24;
            psdu_bits  <= '0;
            o_mem_addr <= '0;
            o_tx_ack   <= 1'b0;
        end else if (state == IDLE) begin
            if (i_tx_req) begin
                state      <= SIGNAL;
                fld_cnt    <= '0;
                sym_cnt    <= '0;
                o_mem_addr <= '0;
            end
        end else if (state == DONE) begin
            // Four-phase handshake, ack waits for the output to drain
            if (!o_tx_ack) begin
                o_tx_ack <= i_fifo_empty;
            end else if (!i_tx_req) begin
                o_tx_ack <= 1'b0;
                state    <= IDLE;
            end
        end else if (emit) begin
            if (field_last) begin
                state   <= next_field;
                fld_cnt <= '0;
            end else begin
                fld_cnt <= fld_cnt + 15'd1;
            end

            // Symbol count runs from SERVICE onward
            if (state != SIGNAL) begin
                sym_cnt <= sym_wrap ? 8'd0 : sym_cnt + 8'd1;
            end

            if (state == SIGNAL && field_last) begin
                dbps       <= dbps_dec;
                psdu_bits  <= (sig_len > 12'd4) ? {sig_len - 12'd4, 3'b000} : '0;
                o_mem_addr <= MEM_ADDR_W'(1);
            end

            if (state == PSDU && fld_cnt[5:0] == 6'd63) begin
                o_mem_addr <= o_mem_addr + MEM_ADDR_W'(1);
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/tx_top.sv
/*
 * Top level of the transmit bit front end.
 * Reads one packet from the caller's word memory on a req/ack handshake
 * and streams rate-1/2 coded bit pairs out over ready/valid.
 */
`timescale 1ns/10ps
`default_nettype none

module tx_top
    import tx_pkg::*;
#(
    parameter int FIFO_DEPTH = 16
) (
    input  wire logic                  clk,
    input  wire logic                  reset_int,
    input  wire logic                  i_tx_req,
    output logic                       o_tx_ack,
    input  wire logic [SCRAM_W-1:0]    i_scram_seed,
    input  wire logic [MEM_WORD_W-1:0] i_mem_data,
    output logic      [MEM_ADDR_W-1:0] o_mem_addr,
    output coded_pair_t                o_pair,
    output logic                       o_pair_valid,
    input  wire logic                  i_pair_ready
);

    tx_bit_t     seq_bit;
    tx_bit_t     scr_bit;
    logic        bit_strobe;
    logic        crc_strobe;
    logic        fcs_bit;
    coded_pair_t enc_pair;
    logic        pair_strobe;
    logic        fifo_full;
    logic        fifo_empty;

    frame_sequencer u_seq (
        .clk          (clk),
        .reset_int    (reset_int),
        .i_tx_req     (i_tx_req),
        .i_mem_data   (i_mem_data),
        .i_fcs_bit    (fcs_bit),
        .i_fifo_full  (fifo_full),
        .i_fifo_empty (fifo_empty),
        .o_tx_ack     (o_tx_ack),
        .o_mem_addr   (o_mem_addr),
        .o_bit        (seq_bit),
        .o_bit_strobe (bit_strobe),
        .o_crc_strobe (crc_strobe)
    );

    crc32_fcs u_crc (
        .clk          (clk),
        .reset_int    (reset_int),
        .i_bit        (seq_bit),
        .i_crc_strobe (crc_strobe),
        .o_fcs_bit    (fcs_bit)
    );

    data_scrambler u_scram (
        .clk          (clk),
        .reset_int    (reset_int),
        .i_scram_seed (i_scram_seed),
        .i_bit        (seq_bit),
        .i_bit_strobe (bit_strobe),
        .o_bit        (scr_bit)
    );

    conv_encoder u_enc (
        .clk           (clk),
        .reset_int     (reset_int),
        .i_bit         (scr_bit),
        .i_bit_strobe  (bit_strobe),
        .o_pair        (enc_pair),
        .o_pair_strobe (pair_strobe)
    );

    coded_pair_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk           (clk),
        .reset_int     (reset_int),
        .i_pair        (enc_pair),
        .i_pair_strobe (pair_strobe),
        .i_pair_ready  (i_pair_ready),
        .o_pair        (o_pair),
        .o_pair_valid  (o_pair_valid),
        .o_full        (fifo_full),
        .o_empty       (fifo_empty)
    );

endmodule

`default_nettype wire

//--- tb/tx_ref_model.svh
/*
 * Reference model of the transmit bit front end.
 * Included inside the testbench module. It reads the packet from pkt_mem
 * and fills exp_pairs with the coded pairs that the packet must produce,
 * working from the 802.11a field, scrambler, CRC and encoder rules.
 */
`ifndef TX_REF_MODEL_SVH
`define TX_REF_MODEL_SVH

// Model state, m_delay[1] is the most recent past encoder input
logic [6:1]  m_delay;
logic [6:0]  m_scram;
logic [31:0] m_crc;

// Data bits per OFDM symbol for each rate code
function automatic int rate_dbps(input logic [3:0] code);
    case (code)
        4'b1011: return 24;
        4'b1111: return 36;
        4'b1010: return 48;
        4'b1110: return 72;
        4'b1001: return 96;
        4'b1101: return 144;
        4'b1000: return 192;
        4'b1100: return 216;
        default: return 24;
    endcase
endfunction

// SIGNAL pairs plus the data field rounded up to whole symbols
function automatic int pair_count(input logic [3:0] code, input int len);
    int data_bits;
    int dbps;
    data_bits = 16 + 8 * (len - 4) + 32 + 6;
    dbps      = rate_dbps(code);
    return 24 + ((data_bits + dbps - 1) / dbps) * dbps;
endfunction

// Generators 133 and 171 octal
function automatic void encode_bit(input logic din);
    logic a_out;
    logic b_out;
    a_out = din ^ m_delay[2] ^ m_delay[3] ^ m_delay[5] ^ m_delay[6];
    b_out = din ^ m_delay[1] ^ m_delay[2] ^ m_delay[3] ^ m_delay[6];
    exp_pairs.push_back({a_out, b_out});
    m_delay = {m_delay[5:1], din};
endfunction

// x^7 + x^4 + 1 scrambler
function automatic logic scramble_bit(input logic din);
    logic fb;
    fb      = m_scram[6] ^ m_scram[3];
    m_scram = {m_scram[5:0], fb};
    return din ^ fb;
endfunction

function automatic void crc_bit(input logic din);
    logic fb;
    fb    = din ^ m_crc[31];
    m_crc = {m_crc[30:0], 1'b0} ^ (fb ? 32'h04C1_1DB7 : 32'h0);
endfunction

function automatic void build_expected(input logic [6:0] seed);
    logic [63:0] sig;
    logic [31:0] fcs;
    logic        din;
    int          len;
    int          psdu_bits;
    int          n_data;
    int          i;
    sig       = pkt_mem[0];
    len       = sig[16:5];
    psdu_bits = 8 * (len - 4);
    exp_pairs.delete();
    m_delay = '0;
    for (i = 0; i < 24; i++) begin
        encode_bit(sig[i]);
    end
    // Data field starts from a clean encoder and a fresh seed
    m_delay = '0;
    m_scram = seed;
    m_crc   = '1;
    for (i = 0; i < 16; i++) begin
        encode_bit(scramble_bit(1'b0));
    end
    for (i = 0; i < psdu_bits; i++) begin
        din = pkt_mem[1 + i / 64][i % 64];
        crc_bit(din);
        encode_bit(scramble_bit(din));
    end
    fcs = ~m_crc;
    for (i = 31; i >= 0; i--) begin
        encode_bit(scramble_bit(fcs[i]));
    end
    for (i = 0; i < 6; i++) begin
        encode_bit(1'b0);
    end
    n_data = 16 + psdu_bits + 32 + 6;
    while (n_data % rate_dbps(sig[3:0]) != 0) begin
        encode_bit(scramble_bit(1'b0));
        n_data++;
    end
endfunction

`endif

//--- tb/tb_tx_top.sv
/*
 * Testbench of the transmit bit front end.
 * Sends 20 random packets through tx_top under random output stalls,
 * checks every coded pair against the reference model, the pair count
 * and the req/ack handshake, and resets once in the middle of a packet.
 */
`timescale 1ns/10ps
`default_nettype none

module tb_tx_top
    import tx_pkg::*;
();

    localparam int N_PKT = 20;

    logic                  clk;
    logic                  reset_int;
    logic                  i_tx_req;
    logic                  o_tx_ack;
    logic [SCRAM_W-1:0]    i_scram_seed;
    logic [MEM_WORD_W-1:0] i_mem_data;
    logic [MEM_ADDR_W-1:0] o_mem_addr;
    coded_pair_t           o_pair;
    logic                  o_pair_valid;
    logic                  i_pair_ready;

    logic [MEM_WORD_W-1:0] pkt_mem [1024];
    coded_pair_t           exp_pairs [$];
    coded_pair_t           held_pair;
    logic [3:0]            pkt_code [N_PKT];
    int                    pkt_len [N_PKT];
    logic [6:0]            pkt_seed [N_PKT];
    logic [3:0]            rate_codes [8] = '{4'hB, 4'hF, 4'hA, 4'hE, 4'h9, 4'hD, 4'h8, 4'hC};
    int                    accepted;
    int                    errors;
    int                    wd_limit;
    bit                    checking;
    bit                    pair_waiting;

    `include "tx_ref_model.svh"

    tx_top #(
        .FIFO_DEPTH (16)
    ) uut (
        .clk          (clk),
        .reset_int    (reset_int),
        .i_tx_req     (i_tx_req),
        .o_tx_ack     (o_tx_ack),
        .i_scram_seed (i_scram_seed),
        .i_mem_data   (i_mem_data),
        .o_mem_addr   (o_mem_addr),
        .o_pair       (o_pair),
        .o_pair_valid (o_pair_valid),
        .i_pair_ready (i_pair_ready)
    );

    // Packet memory answers in the same cycle
    assign i_mem_data = pkt_mem[o_mem_addr];

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        i_pair_ready = 1'b0;
        forever begin
            @(negedge clk);
            i_pair_ready = ($urandom % 5) < 3;
        end
    end

    task automatic stop_on_error(input string msg);
        errors++;
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_low(input string name, input logic value);
        assert (value === 1'b0) else
            stop_on_error($sformatf("** Error at %0d ns: %s = %b, expected 0", $time, name, value));
    endtask

    task automatic check_pair();
        coded_pair_t want;
        if (exp_pairs.size() == 0) begin
            stop_on_error("A pair arrived after the last expected pair of the packet");
        end else begin
            want = exp_pairs.pop_front();
            assert (o_pair === want) else
                stop_on_error($sformatf("** Error at %0d ns: o_pair = %b, expected %b",
                                        $time, o_pair, want));
        end
    endtask

    ////////////////////
    // Output monitor
    ////////////////////
    always @(posedge clk) begin
        if (reset_int) begin
            pair_waiting = 1'b0;
        end else begin
            if (pair_waiting) begin
                assert (o_pair_valid) else
                    stop_on_error("o_pair_valid fell while a pair was waiting");
                assert (o_pair === held_pair) else
                    stop_on_error($sformatf("** Error at %0d ns: o_pair = %b, expected %b",
                                            $time, o_pair, held_pair));
            end
            if (!i_tx_req && !o_tx_ack) begin
                assert (!o_pair_valid) else
                    stop_on_error("A pair became valid without an active request");
            end
            if (checking && o_tx_ack) begin
                assert (exp_pairs.size() == 0) else
                    stop_on_error("o_tx_ack rose before the last pair was accepted");
            end
            if (o_pair_valid && i_pair_ready) begin
                accepted++;
                if (checking) begin
                    check_pair();
                end
            end
            pair_waiting = o_pair_valid && !i_pair_ready;
            held_pair    = o_pair;
        end
    end

    initial begin
        wait (wd_limit > 0);
        repeat (wd_limit) @(posedge clk);
        stop_on_error("Timeout: the packets did not complete in the allowed time");
    end

    // Called at a falling edge with reset already high
    task automatic hold_reset();
        repeat (5) begin
            @(negedge clk);
            check_low("o_tx_ack", o_tx_ack);
            check_low("o_pair_valid", o_pair_valid);
        end
        reset_int = 1'b0;
        @(negedge clk);
        check_low("o_tx_ack", o_tx_ack);
        check_low("o_pair_valid", o_pair_valid);
    endtask

    task automatic load_packet(input logic [3:0] code, input int len);
        logic [63:0] word0;
        int          w;
        word0       = {$urandom, $urandom};
        word0[3:0]  = code;
        word0[16:5] = 12'(len);
        pkt_mem[0]  = word0;
        for (w = 1; w <= (len - 4 + 7) / 8; w++) begin
            pkt_mem[w] = {$urandom, $urandom};
        end
    endtask

    // Start a 6 Mbps packet and pull reset partway through it
    task automatic mid_packet_reset();
        int stop_at;
        load_packet(4'hB, 20);
        i_scram_seed = 7'(1 + $urandom % 127);
        stop_at      = 10 + $urandom % 60;
        accepted     = 0;
        i_tx_req     = 1'b1;
        while (accepted < stop_at) @(negedge clk);
        i_tx_req  = 1'b0;
        reset_int = 1'b1;
        hold_reset();
    endtask

    task automatic run_packet(input int idx);
        int n_exp;
        load_packet(pkt_code[idx], pkt_len[idx]);
        i_scram_seed = pkt_seed[idx];
        build_expected(pkt_seed[idx]);
        n_exp    = pair_count(pkt_code[idx], pkt_len[idx]);
        accepted = 0;
        checking = 1'b1;
        i_tx_req = 1'b1;
        @(negedge clk);
        while (!o_tx_ack) @(negedge clk);
        assert (accepted == n_exp) else
            stop_on_error($sformatf("** Error at %0d ns: o_pair count = %0d, expected %0d",
                                    $time, accepted, n_exp));
        // Ack holds as long as req does
        repeat ($urandom % 4) begin
            @(negedge clk);
            assert (o_tx_ack) else
                stop_on_error("o_tx_ack fell while i_tx_req was still high");
        end
        i_tx_req = 1'b0;
        @(negedge clk);
        check_low("o_tx_ack", o_tx_ack);
        checking = 1'b0;
    endtask

    ////////////////////
    // Main sequence
    ////////////////////
    initial begin
        int total;
        int idx;
        void'($urandom(54734));
        reset_int    = 1'b1;
        i_tx_req     = 1'b0;
        i_scram_seed = '0;
        accepted     = 0;
        errors       = 0;
        wd_limit     = 0;
        checking     = 1'b0;
        pair_waiting = 1'b0;
        for (idx = 0; idx < 1024; idx++) begin
            pkt_mem[idx] = {{6{idx[9:0]}}, idx[3:0]};
        end

        // All eight rates first, then one invalid code, then random rates
        total = pair_count(4'hB, 20);
        for (idx = 0; idx < N_PKT; idx++) begin
            if (idx < 8) begin
                pkt_code[idx] = rate_codes[idx];
            end else if (idx == 8) begin
                pkt_code[idx] = {1'b0, 3'($urandom % 8)};
            end else begin
                pkt_code[idx] = rate_codes[$urandom % 8];
            end
            pkt_len[idx]  = 5 + $urandom % 36;
            pkt_seed[idx] = 7'(1 + $urandom % 127);
            total += pair_count(pkt_code[idx], pkt_len[idx]);
        end
        wd_limit = total * 50 + 2000;

        hold_reset();
        mid_packet_reset();
        for (idx = 0; idx < N_PKT; idx++) begin
            run_packet(idx);
        end

        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
+incdir+tb
hw/tx_pkg.sv
hw/crc32_fcs.sv
hw/data_scrambler.sv
hw/conv_encoder.sv
hw/coded_pair_fifo.sv
hw/frame_sequencer.sv
hw/tx_top.sv
tb/tb_tx_top.sv

//--- Bender.yml
package:
  name: ofdm_tx_front_end

sources:
  - hw/tx_pkg.sv
  - hw/crc32_fcs.sv
  - hw/data_scrambler.sv
  - hw/conv_encoder.sv
  - hw/coded_pair_fifo.sv
  - hw/frame_sequencer.sv
  - hw/tx_top.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_tx_top.sv
